// File: hdl/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Widths and vector types
  // ==================================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 8;
  localparam int DIV_W        = 16;

  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [FLASH_DATA_W-1:0] flash_word_t;
  typedef logic [SAMPLE_W-1:0]     sample_t;
  typedef logic [DIV_W-1:0]        div_t;

  // ==================================================
  // Playback rate
  // ==================================================
  // Clock cycles per sample, about 22 kHz at 50 MHz
  localparam div_t DEFAULT_DIV = 16'd2272;
  localparam div_t SPEED_STEP  = 16'd100;
  localparam div_t MIN_DIV     = 16'd500;
  localparam div_t MAX_DIV     = 16'd9000;

  // Repeat interval of a held button, 100 ms
  localparam int DEFAULT_REPEAT_CYCLES = 5_000_000;

  // Last word of the song in flash
  localparam flash_addr_t DEFAULT_LAST_ADDR = 23'h7FFFF;

  // ==================================================
  // Keyboard commands
  // ==================================================
  localparam logic [7:0] SCAN_PLAY     = 8'h24;
  localparam logic [7:0] SCAN_PAUSE    = 8'h23;
  localparam logic [7:0] SCAN_FORWARD  = 8'h2B;
  localparam logic [7:0] SCAN_BACKWARD = 8'h32;
  localparam logic [7:0] SCAN_RESTART  = 8'h2D;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_PLAY,
    CMD_PAUSE,
    CMD_FORWARD,
    CMD_BACKWARD,
    CMD_RESTART
  } cmd_t;

  // Fetcher states
  typedef enum logic [1:0] {
    ST_FETCH,
    ST_WAIT_DATA,
    ST_PLAY_LO,
    ST_PLAY_HI
  } fetch_state_t;

endpackage

// File: hdl/kbd_command_decoder.sv
`timescale 1ns/1ps

module kbd_command_decoder
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic [7:0] scan_code,
  input  logic       scan_valid,
  output logic       playing,
  output logic       forward,
  output logic       restart
);

  cmd_t cmd;

  // Scan code to command, only in the valid cycle
  always_comb
  begin
    cmd = CMD_NONE;
    if (scan_valid)
    begin
      case (scan_code)
        SCAN_PLAY:     cmd = CMD_PLAY;
        SCAN_PAUSE:    cmd = CMD_PAUSE;
        SCAN_FORWARD:  cmd = CMD_FORWARD;
        SCAN_BACKWARD: cmd = CMD_BACKWARD;
        SCAN_RESTART:  cmd = CMD_RESTART;
        default:       cmd = CMD_NONE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing <= 1'b0;
      forward <= 1'b1;
      restart <= 1'b0;
    end
    else
    begin
      restart <= (cmd == CMD_RESTART);
      case (cmd)
        CMD_PLAY:     playing <= 1'b1;
        CMD_PAUSE:    playing <= 1'b0;
        CMD_FORWARD:  forward <= 1'b1;
        CMD_BACKWARD: forward <= 1'b0;
        default:      ;
      endcase
    end
  end

  // Restart reaches the fetcher as a single-cycle pulse
  assert property (@(posedge CLK_50M) disable iff (rst) restart |=> !restart);

endmodule

// File: hdl/speed_control.sv
`timescale 1ns/1ps

module speed_control
  import ipod_pkg::*;
#(
  parameter int repeat_cycles = DEFAULT_REPEAT_CYCLES
) (
  input  logic CLK_50M,
  input  logic rst,
  input  logic btn_faster,
  input  logic btn_slower,
  input  logic btn_default,
  output div_t divider
);

  // Bit 0 faster, bit 1 slower, bit 2 default
  logic [2:0]  sync_a;
  logic [2:0]  btn_s;
  logic [2:0]  btn_prev;
  logic [2:0]  press;
  logic        held;
  logic        rep_tick;
  logic [31:0] rep_cnt;
  logic        ev_faster;
  logic        ev_slower;
  logic        ev_default;
  logic        cand_valid;
  div_t        cand;
  div_t        cand_next;

  // ==================================================
  // Synchronisers and press edges
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      sync_a   <= '0;
      btn_s    <= '0;
      btn_prev <= '0;
    end
    else
    begin
      sync_a   <= {btn_default, btn_slower, btn_faster};
      btn_s    <= sync_a;
      btn_prev <= btn_s;
    end
  end

  assign press    = btn_s & ~btn_prev;
  assign held     = btn_s[0] | btn_s[1];
  assign rep_tick = held && (press[1:0] == 2'b00) && (rep_cnt == repeat_cycles - 1);

  // Repeat interval restarts at each press
  always_ff @(posedge CLK_50M)
  begin
    if (rst || !held || press[1:0] != 2'b00 || rep_tick)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  // ==================================================
  // Step events, clamp, divider register
  // ==================================================
  always_comb
  begin
    if (ev_default)
      cand_next = DEFAULT_DIV;
    else if (ev_faster)
      cand_next = (divider < MIN_DIV + SPEED_STEP) ? MIN_DIV : divider - SPEED_STEP;
    else
      cand_next = (divider > MAX_DIV - SPEED_STEP) ? MAX_DIV : divider + SPEED_STEP;
  end

  always_ff @(posedge CLK_50M)
  begin
    cand <= cand_next;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      ev_faster  <= 1'b0;
      ev_slower  <= 1'b0;
      ev_default <= 1'b0;
      cand_valid <= 1'b0;
      divider    <= DEFAULT_DIV;
    end
    else
    begin
      ev_faster  <= press[0] | (btn_s[0] & rep_tick);
      ev_slower  <= press[1] | (btn_s[1] & rep_tick);
      ev_default <= press[2];
      cand_valid <= ev_faster | ev_slower | ev_default;
      if (cand_valid)
        divider <= cand;
    end
  end

  assert property (@(posedge CLK_50M) disable iff (rst)
    cand_valid |=> (divider >= MIN_DIV) && (divider <= MAX_DIV));

endmodule

// File: hdl/flash_sample_fetcher.sv
`timescale 1ns/1ps

module flash_sample_fetcher
  import ipod_pkg::*;
#(
  parameter flash_addr_t last_addr = DEFAULT_LAST_ADDR
) (
  input  logic        CLK_50M,
  input  logic        rst,
  input  logic        playing,
  input  logic        forward,
  input  logic        restart,
  input  div_t        divider,
  output logic        flash_read,
  input  logic        flash_waitrequest,
  output flash_addr_t flash_address,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output sample_t     sample,
  output logic        sample_valid
);

  fetch_state_t state;
  flash_word_t  word_q;
  div_t         rate_cnt;
  logic         word_fwd;
  logic         restart_pend;
  logic         drop;
  logic         stalled;
  logic         do_restart;
  logic         emit;
  logic         first_half;
  flash_addr_t  start_addr;
  flash_addr_t  next_addr;

  // A restart waits while a read is held off by waitrequest
  assign stalled    = flash_read & flash_waitrequest;
  assign do_restart = (restart | restart_pend) & ~stalled;
  assign emit       = (state == ST_PLAY_LO || state == ST_PLAY_HI) && playing &&
                      (rate_cnt >= divider - 1'b1) && !do_restart;
  assign first_half = ((state == ST_PLAY_LO) == word_fwd);
  assign start_addr = forward ? '0 : last_addr;

  always_comb
  begin
    if (forward)
      next_addr = (flash_address == last_addr) ? '0 : flash_address + 1'b1;
    else
      next_addr = (flash_address == '0) ? last_addr : flash_address - 1'b1;
  end

  // ==================================================
  // Fetch FSM
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= ST_FETCH;
      flash_address <= '0;
      flash_read    <= 1'b0;
      sample_valid  <= 1'b0;
      rate_cnt      <= '0;
      word_fwd      <= 1'b1;
      restart_pend  <= 1'b0;
      drop          <= 1'b0;
    end
    else
    begin
      sample_valid <= emit;
      if (flash_readdatavalid)
        drop <= 1'b0;
      if (do_restart)
      begin
        restart_pend  <= 1'b0;
        state         <= ST_FETCH;
        flash_address <= start_addr;
        rate_cnt      <= '0;
        // Data of the read in flight is thrown away
        if (flash_read)
        begin
          flash_read <= 1'b0;
          drop       <= 1'b1;
        end
        else if (state == ST_WAIT_DATA && !flash_readdatavalid)
          drop <= 1'b1;
      end
      else
      begin
        if (restart)
          restart_pend <= 1'b1;
        case (state)
          ST_FETCH:
          begin
            if (!flash_read)
              flash_read <= !drop;
            else if (!flash_waitrequest)
            begin
              flash_read <= 1'b0;
              state      <= ST_WAIT_DATA;
            end
          end
          ST_WAIT_DATA:
          begin
            if (flash_readdatavalid)
            begin
              rate_cnt <= '0;
              word_fwd <= forward;
              state    <= forward ? ST_PLAY_LO : ST_PLAY_HI;
            end
          end
          default:
          begin
            // Play states, frozen while paused
            if (emit)
            begin
              rate_cnt <= '0;
              if (first_half)
                state <= (state == ST_PLAY_LO) ? ST_PLAY_HI : ST_PLAY_LO;
              else
              begin
                flash_address <= next_addr;
                state         <= ST_FETCH;
              end
            end
            else if (playing)
              rate_cnt <= rate_cnt + 1'b1;
          end
        endcase
      end
    end
  end

  // Word buffer and sample byte
  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_WAIT_DATA && flash_readdatavalid)
      word_q <= flash_readdata;
    if (emit)
      sample <= (state == ST_PLAY_LO) ? word_q[15:8] : word_q[31:24];
  end

  assert property (@(posedge CLK_50M) disable iff (rst)
    stalled |=> flash_read && $stable(flash_address));

  assert property (@(posedge CLK_50M) disable iff (rst)
    (state == ST_WAIT_DATA) |-> !flash_read);

endmodule

// File: hdl/hex_display.sv
`timescale 1ns/1ps

module hex_display
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  div_t       divider,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5
);

  div_t div_q;

  // Segments g..a, a lit segment is 0
  function automatic logic [6:0] seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      div_q <= DEFAULT_DIV;
    else
      div_q <= divider;
  end

  assign hex0 = seg_decode(div_q[3:0]);
  assign hex1 = seg_decode(div_q[7:4]);
  assign hex2 = seg_decode(div_q[11:8]);
  assign hex3 = seg_decode(div_q[15:12]);
  // upper two digits unused
  assign hex4 = 7'h7F;
  assign hex5 = 7'h7F;

endmodule

// File: hdl/ipod_top.sv
`timescale 1ns/1ps

module ipod_top
  import ipod_pkg::*;
#(
  parameter flash_addr_t last_addr     = DEFAULT_LAST_ADDR,
  parameter int          repeat_cycles = DEFAULT_REPEAT_CYCLES
) (
  input  logic        CLK_50M,
  input  logic        rst,
  input  logic [7:0]  scan_code,
  input  logic        scan_valid,
  input  logic        btn_faster,
  input  logic        btn_slower,
  input  logic        btn_default,
  output logic        flash_read,
  input  logic        flash_waitrequest,
  output flash_addr_t flash_address,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output sample_t     sample,
  output logic        sample_valid,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  logic playing;
  logic forward;
  logic restart;
  div_t divider;

  // ==================================================
  // Control
  // ==================================================
  kbd_command_decoder i_kbd (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .scan_code  (scan_code),
    .scan_valid (scan_valid),
    .playing    (playing),
    .forward    (forward),
    .restart    (restart)
  );

  speed_control #(.repeat_cycles(repeat_cycles)) i_speed (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .btn_faster  (btn_faster),
    .btn_slower  (btn_slower),
    .btn_default (btn_default),
    .divider     (divider)
  );

  // ==================================================
  // Datapath and display
  // ==================================================
  flash_sample_fetcher #(.last_addr(last_addr)) i_fetch (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .playing             (playing),
    .forward             (forward),
    .restart             (restart),
    .divider             (divider),
    .flash_read          (flash_read),
    .flash_waitrequest   (flash_waitrequest),
    .flash_address       (flash_address),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid)
  );

  hex_display i_hex (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .divider (divider),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

// File: tb/flash_model.sv
`timescale 1ns/1ps

module flash_model
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst,
  input  logic        flash_read,
  output logic        flash_waitrequest,
  input  flash_addr_t flash_address,
  output flash_word_t flash_readdata,
  output logic        flash_readdatavalid
);

  integer      seed = 32'h6d94_928a;
  int          wait_left;
  int          lat_left;
  logic        busy;
  flash_addr_t addr_q;

  // Byte k of word a holds (4a+k) mod 256
  function automatic flash_word_t word_at(input flash_addr_t a);
    logic [7:0] base;
    base = {a[5:0], 2'b00};
    word_at = {base + 8'd3, base + 8'd2, base + 8'd1, base};
  endfunction

  // Wait states count down while a read is held off
  assign flash_waitrequest = flash_read && (wait_left != 0);

  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      wait_left           <= {$random(seed)} % 3;
      lat_left            <= 0;
      busy                <= 1'b0;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      if (flash_read && wait_left != 0)
        wait_left <= wait_left - 1;
      else if (flash_read)
      begin
        // Read accepted, pick latency now and wait states for the next read
        addr_q    <= flash_address;
        busy      <= 1'b1;
        lat_left  <= 1 + {$random(seed)} % 4;
        wait_left <= {$random(seed)} % 3;
      end
      if (busy)
      begin
        if (lat_left == 1)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= word_at(addr_q);
          busy                <= 1'b0;
        end
        else
          lat_left <= lat_left - 1;
      end
    end
  end

endmodule

// File: tb/tb_ipod_top.sv
`timescale 1ns/1ps

module tb_ipod_top
  import ipod_pkg::*;
();

  localparam int          CLK_PERIOD  = 20;
  localparam flash_addr_t LAST_ADDR   = 23'd7;
  localparam int          REPEAT      = 40;
  localparam int          SAMPLE_WAIT = 3 * DEFAULT_DIV + 200;

  // Cycle budgets of the tests
  localparam int BUDGET_RESET    = 1000;
  localparam int BUDGET_SPEED    = 3000;
  localparam int BUDGET_FORWARD  = 58000;
  localparam int BUDGET_PAUSE    = 12000;
  localparam int BUDGET_BACKWARD = 12000;
  localparam int BUDGET_RATE     = 14000;
  localparam int WATCHDOG_NS     = (BUDGET_RESET + BUDGET_SPEED + BUDGET_FORWARD +
                                    BUDGET_PAUSE + BUDGET_BACKWARD + BUDGET_RATE) * CLK_PERIOD;

  logic        CLK_50M;
  logic        rst;
  logic [7:0]  scan_code;
  logic        scan_valid;
  logic        btn_faster;
  logic        btn_slower;
  logic        btn_default;
  logic        flash_read;
  logic        flash_waitrequest;
  flash_addr_t flash_address;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  sample_t     sample;
  logic        sample_valid;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;

  int      errors = 0;
  int      cycle = 0;
  sample_t sample_q[$];
  int      time_q[$];

  // Expected playback position
  int   exp_addr;
  logic exp_hi;
  logic exp_fwd;

  ipod_top #(.last_addr(LAST_ADDR), .repeat_cycles(REPEAT)) i_dut (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .scan_code           (scan_code),
    .scan_valid          (scan_valid),
    .btn_faster          (btn_faster),
    .btn_slower          (btn_slower),
    .btn_default         (btn_default),
    .flash_read          (flash_read),
    .flash_waitrequest   (flash_waitrequest),
    .flash_address       (flash_address),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  flash_model i_flash (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_read          (flash_read),
    .flash_waitrequest   (flash_waitrequest),
    .flash_address       (flash_address),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  initial CLK_50M = 1'b0;
  always #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;

  always @(posedge CLK_50M)
    cycle <= cycle + 1;

  // Record each sample with its cycle number
  always @(negedge CLK_50M)
  begin
    if (!rst && sample_valid)
    begin
      sample_q.push_back(sample);
      time_q.push_back(cycle);
    end
  end

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_sample(input sample_t got, input sample_t want, input string what);
    if (got !== want)
    begin
      $display("[FAIL] time=%0d ns %s got %0d expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_div(input div_t got, input div_t want, input string what);
    if (got !== want)
    begin
      $display("[FAIL] time=%0d ns %s got %0d expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_hex(input logic [6:0] got, input logic [6:0] want, input string what);
    if (got !== want)
    begin
      $display("[FAIL] time=%0d ns %s got %h expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  // Lit segments g..a per digit before inversion to active low
  function automatic logic [6:0] seg_expected(input logic [3:0] digit);
    logic [6:0] lit;
    case (digit)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    seg_expected = ~lit;
  endfunction

  task automatic check_display(input div_t want);
    @(negedge CLK_50M);
    check_div(i_dut.divider, want, "divider");
    check_hex(hex0, seg_expected(want[3:0]), "hex0");
    check_hex(hex1, seg_expected(want[7:4]), "hex1");
    check_hex(hex2, seg_expected(want[11:8]), "hex2");
    check_hex(hex3, seg_expected(want[15:12]), "hex3");
    check_hex(hex4, 7'h7F, "hex4");
    check_hex(hex5, 7'h7F, "hex5");
  endtask

  // ==================================================
  // Stimulus helpers
  // ==================================================
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK_50M);
  endtask

  task automatic send_scan(input logic [7:0] code);
    @(posedge CLK_50M);
    #1;
    scan_code  = code;
    scan_valid = 1'b1;
    @(posedge CLK_50M);
    #1;
    scan_valid = 1'b0;
  endtask

  // sel 0 faster, 1 slower, 2 default
  task automatic press_button(input int sel, input int hold);
    @(posedge CLK_50M);
    #1;
    btn_faster  = (sel == 0);
    btn_slower  = (sel == 1);
    btn_default = (sel == 2);
    repeat (hold) @(posedge CLK_50M);
    #1;
    btn_faster  = 1'b0;
    btn_slower  = 1'b0;
    btn_default = 1'b0;
    // Divider and display settle
    wait_cycles(10);
  endtask

  // Low half 4a+1 and high half 4a+3 in playback order
  task automatic expect_next(output sample_t want);
    want = sample_t'(4 * exp_addr + (exp_hi ? 3 : 1));
    if (exp_hi == exp_fwd)
    begin
      if (exp_fwd)
        exp_addr = (exp_addr == LAST_ADDR) ? 0 : exp_addr + 1;
      else
        exp_addr = (exp_addr == 0) ? LAST_ADDR : exp_addr - 1;
      exp_hi = !exp_fwd;
    end
    else
      exp_hi = !exp_hi;
  endtask

  task automatic take_sample(output sample_t s, output int t);
    sample_t want;
    int      waited;
    waited = 0;
    while (sample_q.size() == 0 && waited < SAMPLE_WAIT)
    begin
      @(posedge CLK_50M);
      waited++;
    end
    if (sample_q.size() == 0)
    begin
      $display("Timed out after %0d cycles waiting for a sample", SAMPLE_WAIT);
      errors++;
      s = '0;
      t = 0;
    end
    else
    begin
      s = sample_q.pop_front();
      t = time_q.pop_front();
      expect_next(want);
      check_sample(s, want, "sample");
    end
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset();
    wait_cycles(300);
    if (sample_q.size() != 0)
    begin
      $display("Samples were played while paused after reset");
      errors++;
    end
    check_display(DEFAULT_DIV);
  endtask

  task automatic test_speed();
    press_button(0, 5);
    check_display(DEFAULT_DIV - SPEED_STEP);
    press_button(1, 5);
    check_display(DEFAULT_DIV);
    press_button(0, 30 * REPEAT);
    check_display(MIN_DIV);
    press_button(2, 5);
    check_display(DEFAULT_DIV);
  endtask

  task automatic test_forward();
    sample_t s;
    int      t;
    int      prev_t;
    int      i;
    exp_addr = 0;
    exp_hi   = 1'b0;
    exp_fwd  = 1'b1;
    send_scan(SCAN_PLAY);
    prev_t = 0;
    // Twenty samples run through word 7 and wrap to word 0
    for (i = 0; i < 20; i++)
    begin
      take_sample(s, t);
      if (i % 2 == 1)
        check_div(div_t'(t - prev_t), DEFAULT_DIV, "forward sample spacing");
      prev_t = t;
    end
  endtask

  task automatic test_pause();
    sample_t s;
    int      t;
    int      queued;
    send_scan(SCAN_PAUSE);
    wait_cycles(3);
    queued = sample_q.size();
    wait_cycles(5000);
    if (sample_q.size() != queued)
    begin
      $display("Samples arrived during the pause");
      errors++;
    end
    send_scan(SCAN_PLAY);
    repeat (queued + 1) take_sample(s, t);
  endtask

  task automatic test_backward();
    sample_t s;
    int      t;
    send_scan(SCAN_BACKWARD);
    send_scan(SCAN_RESTART);
    wait_cycles(3);
    // Samples from before the restart do not count
    sample_q.delete();
    time_q.delete();
    exp_addr = LAST_ADDR;
    exp_hi   = 1'b1;
    exp_fwd  = 1'b0;
    repeat (4) take_sample(s, t);
  endtask

  task automatic test_rate();
    sample_t s;
    sample_t prev;
    int      t;
    int      prev_t;
    int      t_change;
    int      i;
    logic    found;
    press_button(0, 5);
    check_display(DEFAULT_DIV - SPEED_STEP);
    t_change = cycle;
    found    = 1'b0;
    prev     = '0;
    prev_t   = 0;
    for (i = 0; i < 5 && !found; i++)
    begin
      take_sample(s, t);
      // Backward pair is the high then the low half of one word
      if (i > 0 && prev_t >= t_change && prev[1:0] == 2'b11 && s == prev - 2)
      begin
        check_div(div_t'(t - prev_t), DEFAULT_DIV - SPEED_STEP, "sample spacing after tap");
        found = 1'b1;
      end
      prev   = s;
      prev_t = t;
    end
    if (!found)
    begin
      $display("No two samples of one word were seen after the faster tap");
      errors++;
    end
  endtask

  initial
  begin
    rst         = 1'b1;
    scan_code   = '0;
    scan_valid  = 1'b0;
    btn_faster  = 1'b0;
    btn_slower  = 1'b0;
    btn_default = 1'b0;
    repeat (4) @(posedge CLK_50M);
    #1;
    rst = 1'b0;
    test_reset();
    test_speed();
    test_forward();
    test_pause();
    test_backward();
    test_rate();
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: compile.f
hdl/ipod_pkg.sv
hdl/kbd_command_decoder.sv
hdl/speed_control.sv
hdl/flash_sample_fetcher.sv
hdl/hex_display.sv
hdl/ipod_top.sv
tb/flash_model.sv
tb/tb_ipod_top.sv

// File: Bender.yml
package:
  name: ipod_sample_player

sources:
  - files:
      - hdl/ipod_pkg.sv
      - hdl/kbd_command_decoder.sv
      - hdl/speed_control.sv
      - hdl/flash_sample_fetcher.sv
      - hdl/hex_display.sv
      - hdl/ipod_top.sv
  - target: test
    files:
      - tb/flash_model.sv
      - tb/tb_ipod_top.sv
